// ==== common/hazard_pkg.sv ====
//////////////////////////////////////////////////
// shared types and opcode constants for the hazard unit
// import into any module that decodes instructions
//////////////////////////////////////////////////

package hazard_pkg;

    // one 16-bit instruction word
    // [15:12] opcode, [11:8] rd, [7:4] rs, [3:0] rt or imm4
    typedef logic [15:0] instr_t;

    // register number, sixteen registers
    typedef logic [3:0] reg_addr_t;

    // major opcode field
    typedef logic [3:0] opcode_t;

    // register alu ops, read rs and rt, write rd
    localparam opcode_t op_add  = 4'h0;
    localparam opcode_t op_sub  = 4'h1;
    localparam opcode_t op_and  = 4'h2;
    localparam opcode_t op_or   = 4'h3;
    localparam opcode_t op_xor  = 4'h4;

    // immediate alu ops, low field is imm4 and not a register
    localparam opcode_t op_ror  = 4'h5;
    localparam opcode_t op_addi = 4'h6;

    // memory ops, both use rs as the base
    localparam opcode_t op_lw   = 4'h8;
    localparam opcode_t op_sw   = 4'h9;

    // byte load into rd, no source register
    localparam opcode_t op_lhb  = 4'ha;

    // control flow
    localparam opcode_t op_b    = 4'hc;
    localparam opcode_t op_br   = 4'hd;
    localparam opcode_t op_nop  = 4'he;
    localparam opcode_t op_hlt  = 4'hf;

    // r0 reads as zero, writes to it are dropped
    localparam reg_addr_t zero_reg = 4'h0;

endpackage

// ==== common/hazard_if.sv ====
//////////////////////////////////////////////////
// bundles shared between decode, the detectors and control
// fd_fields_if holds the decoded IF/ID instruction
// pipe_rec_if holds what ID/EX and EX/MEM will write back
//////////////////////////////////////////////////

interface fd_fields_if import hazard_pkg::*;;

    // register fields of the instruction in decode
    reg_addr_t fd_rs;
    reg_addr_t fd_rt;
    reg_addr_t fd_rd;

    // what the opcode really does, all qualified by fd_valid
    logic      rs_used;
    logic      rt_used;
    logic      rd_written;
    logic      is_load;
    logic      is_store;
    // any branch, op_b or op_br
    logic      is_br;

    modport decode (output fd_rs, fd_rt, fd_rd, rs_used, rt_used, rd_written,
                    is_load, is_store, is_br);
    modport detect (input fd_rs, fd_rt, fd_rd, rs_used, rt_used, rd_written,
                    is_load, is_store, is_br);

endinterface

interface pipe_rec_if import hazard_pkg::*;;

    // instruction now in execute
    reg_addr_t dx_rd;
    logic      dx_regwrite;
    logic      dx_memread;
    // instruction now in memory
    reg_addr_t xm_rd;
    logic      xm_regwrite;

    modport owner  (output dx_rd, dx_regwrite, dx_memread, xm_rd, xm_regwrite);
    modport detect (input dx_rd, dx_regwrite, dx_memread, xm_rd, xm_regwrite);

endinterface

// ==== source/instr_decode.sv ====
//////////////////////////////////////////////////
// decodes the IF/ID instruction for hazard checks
// reports register fields and which of them are really read
//////////////////////////////////////////////////

module instr_decode
    import hazard_pkg::*;
(
    input  instr_t      fd_instr,
    input  logic        fd_valid,
    fd_fields_if.decode fields
);

    opcode_t opcode;

    // raw opcode properties before the valid qualifier
    logic rs_read;
    logic rt_read;
    logic rd_write;
    logic load_op;
    logic store_op;
    logic branch_op;

    // fixed field positions
    assign opcode       = fd_instr[15:12];
    assign fields.fd_rd = fd_instr[11:8];
    assign fields.fd_rs = fd_instr[7:4];
    assign fields.fd_rt = fd_instr[3:0];

    always_comb begin
        // unused opcodes 7 and 11 fall through as no-ops
        rs_read   = 1'b0;
        rt_read   = 1'b0;
        rd_write  = 1'b0;
        load_op   = 1'b0;
        store_op  = 1'b0;
        branch_op = 1'b0;
        case (opcode)
            op_add, op_sub, op_and, op_or, op_xor: begin
                rs_read  = 1'b1;
                rt_read  = 1'b1;
                rd_write = 1'b1;
            end
            op_ror, op_addi: begin
                // low field is imm4, never a dependency
                rs_read  = 1'b1;
                rd_write = 1'b1;
            end
            op_lw: begin
                rs_read  = 1'b1;
                rd_write = 1'b1;
                load_op  = 1'b1;
            end
            op_sw: begin
                // only the base counts as a read here
                // store data in rd is picked up by mem-to-mem forwarding
                rs_read  = 1'b1;
                store_op = 1'b1;
            end
            op_lhb: begin
                rd_write = 1'b1;
            end
            op_b: begin
                branch_op = 1'b1;
            end
            op_br: begin
                // target address comes from rs
                rs_read   = 1'b1;
                branch_op = 1'b1;
            end
            default: begin
                // op_nop, op_hlt and the holes read and write nothing
            end
        endcase
    end

    // an empty IF/ID slot looks like a nop to everyone downstream
    assign fields.rs_used    = fd_valid & rs_read;
    assign fields.rt_used    = fd_valid & rt_read;
    assign fields.rd_written = fd_valid & rd_write;
    assign fields.is_load    = fd_valid & load_op;
    assign fields.is_store   = fd_valid & store_op;
    assign fields.is_br      = fd_valid & branch_op;

endmodule

// ==== hazard/load_use_detect.sv ====
//////////////////////////////////////////////////
// load-use check between decode and execute
// one cycle stall, forwarding covers the rest
//////////////////////////////////////////////////

module load_use_detect
    import hazard_pkg::*;
(
    fd_fields_if.detect fields,
    pipe_rec_if.detect  recs,
    output logic        load_stall
);

    // load in execute whose result is a real register
    logic load_in_ex;
    // per-operand match against the load destination
    logic rs_dep;
    logic rt_dep;

    // a load to r0 produces nothing worth waiting for
    assign load_in_ex = recs.dx_memread & (recs.dx_rd != zero_reg);

    // base register of any op, first source of alu ops
    assign rs_dep = fields.rs_used & (fields.fd_rs == recs.dx_rd);

    // second source only for register alu ops
    // stores and immediate ops leave rt_used low, their low field is an offset
    // store data in rd is forwarded from memory to memory
    assign rt_dep = fields.rt_used & (fields.fd_rt == recs.dx_rd);

    // once the load moves to memory the bubble in execute clears this
    assign load_stall = load_in_ex & (rs_dep | rt_dep);

endmodule

// ==== hazard/branch_reg_detect.sv ====
//////////////////////////////////////////////////
// register branch check against execute and memory
// stalls a taken op_br until its rs has left memory
//////////////////////////////////////////////////

module branch_reg_detect
    import hazard_pkg::*;
(
    fd_fields_if.detect fields,
    pipe_rec_if.detect  recs,
    input  logic        fd_branch_taken,
    output logic        branch_stall
);

    // taken branch that reads rs, only op_br fits
    logic reg_branch;
    // producer of rs still in flight
    logic dx_dep;
    logic xm_dep;

    // op_b reads no register so rs_used singles out op_br
    assign reg_branch = fields.is_br & fields.rs_used & fd_branch_taken;

    // execute stage writer, gives two stall cycles
    assign dx_dep = recs.dx_regwrite &
                    (recs.dx_rd != zero_reg) &
                    (recs.dx_rd == fields.fd_rs);

    // memory stage writer, gives one stall cycle
    assign xm_dep = recs.xm_regwrite &
                    (recs.xm_rd != zero_reg) &
                    (recs.xm_rd == fields.fd_rs);

    // stores and branches never set regwrite so they pass straight through
    assign branch_stall = reg_branch & (dx_dep | xm_dep);

endmodule

// ==== hazard/hazard_control.sv ====
//////////////////////////////////////////////////
// merges both stall sources into hold, bubble and flush
// also keeps the ID/EX and EX/MEM write records
//////////////////////////////////////////////////

module hazard_control (
    input  logic        clk,
    input  logic        reset,
    fd_fields_if.detect fields,
    pipe_rec_if.owner   recs,
    input  logic        load_stall,
    input  logic        branch_stall,
    input  logic        fd_branch_taken,
    output logic        pc_hold,
    output logic        fd_hold,
    output logic        dx_bubble,
    output logic        fd_flush
);

    // single stall level for the whole front end
    logic stall;

    assign stall = load_stall | branch_stall;

    // pc and IF/ID freeze while a nop goes into ID/EX
    assign pc_hold   = stall;
    assign fd_hold   = stall;
    assign dx_bubble = stall;

    // a stalled branch comes back next cycle, flush only once it can go
    // is_br already carries fd_valid
    assign fd_flush = fields.is_br & fd_branch_taken & ~stall;

    // write flags of the records
    // the decode flags are already low for an empty slot, so only the
    // stall has to be folded in for the bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            recs.dx_regwrite <= 1'b0;
            recs.dx_memread  <= 1'b0;
            recs.xm_regwrite <= 1'b0;
        end else begin
            // execute moves on to memory every cycle
            recs.xm_regwrite <= recs.dx_regwrite;
            // decode moves on to execute unless held
            recs.dx_regwrite <= fields.rd_written & ~stall;
            recs.dx_memread  <= fields.is_load & ~stall;
        end
    end

    // destination numbers follow along
    // only looked at while the matching write flag is set
    always_ff @(posedge clk) begin
        recs.xm_rd <= recs.dx_rd;
        recs.dx_rd <= fields.fd_rd;
    end

endmodule

// ==== source/hazard_top.sv ====
//////////////////////////////////////////////////
// hazard detection top level, sits beside decode
// feed it the IF/ID word, get stall and flush levels back
//////////////////////////////////////////////////

module hazard_top
    import hazard_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   fd_valid,
    input  instr_t fd_instr,
    input  logic   fd_branch_taken,
    output logic   pc_hold,
    output logic   fd_hold,
    output logic   dx_bubble,
    output logic   fd_flush
);

    // decoded instruction in decode
    fd_fields_if fields ();
    // write records of execute and memory
    pipe_rec_if  recs ();

    // stall requests from the two detectors
    logic load_stall;
    logic branch_stall;

    instr_decode i_instr_decode (
        .fd_instr (fd_instr),
        .fd_valid (fd_valid),
        .fields   (fields.decode)
    );

    load_use_detect i_load_use_detect (
        .fields     (fields.detect),
        .recs       (recs.detect),
        .load_stall (load_stall)
    );

    branch_reg_detect i_branch_reg_detect (
        .fields          (fields.detect),
        .recs            (recs.detect),
        .fd_branch_taken (fd_branch_taken),
        .branch_stall    (branch_stall)
    );

    // owns the records and drives all four outputs
    hazard_control i_hazard_control (
        .clk             (clk),
        .reset           (reset),
        .fields          (fields.detect),
        .recs            (recs.owner),
        .load_stall      (load_stall),
        .branch_stall    (branch_stall),
        .fd_branch_taken (fd_branch_taken),
        .pc_hold         (pc_hold),
        .fd_hold         (fd_hold),
        .dx_bubble       (dx_bubble),
        .fd_flush        (fd_flush)
    );

endmodule

// ==== testbench/hazard_tb.sv ====
//////////////////////////////////////////////////
// testbench for the hazard unit top level
// directed hazard cases, then a random stream against a reference model
//////////////////////////////////////////////////

module hazard_tb
    import hazard_pkg::*;
();

    // cycles an instruction may sit in decode before giving up
    localparam int hold_limit = 8;

    logic   clk;
    logic   reset;
    logic   fd_valid;
    instr_t fd_instr;
    logic   fd_branch_taken;
    logic   pc_hold;
    logic   fd_hold;
    logic   dx_bubble;
    logic   fd_flush;

    // reference copy of the ID/EX and EX/MEM write records
    reg_addr_t m_dx_rd = '0;
    logic      m_dx_wr = 1'b0;
    logic      m_dx_ld = 1'b0;
    reg_addr_t m_xm_rd = '0;
    logic      m_xm_wr = 1'b0;

    // what the last rising edge saw, read back on the falling edge
    logic model_stall = 1'b0;
    logic seen_hold   = 1'b0;
    logic seen_flush  = 1'b0;

    logic [3:0] expected;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int failed_tests = 0;
    int err_mark = 0;
    int n_stall;
    logic n_flush;

    hazard_top i_hazard_top (
        .clk             (clk),
        .reset           (reset),
        .fd_valid        (fd_valid),
        .fd_instr        (fd_instr),
        .fd_branch_taken (fd_branch_taken),
        .pc_hold         (pc_hold),
        .fd_hold         (fd_hold),
        .dx_bubble       (dx_bubble),
        .fd_flush        (fd_flush)
    );

    always #5 clk = ~clk;

    function automatic instr_t make_instr(opcode_t op, reg_addr_t rd, reg_addr_t rs,
                                          reg_addr_t rt);
        return {op, rd, rs, rt};
    endfunction

    // alu ops 0 to 6, lw and lhb put a result in rd
    function automatic logic writes_rd(opcode_t op);
        return (op <= op_addi) || (op == op_lw) || (op == op_lhb);
    endfunction

    // expected {pc_hold, fd_hold, dx_bubble, fd_flush} for this cycle
    function automatic logic [3:0] expect_outputs(instr_t instr, logic valid, logic taken);
        opcode_t   op;
        reg_addr_t rs;
        reg_addr_t rt;
        logic      rs_rd;
        logic      rt_rd;
        logic      ld_hz;
        logic      br_hz;
        logic      stall;
        logic      flush;
        op = instr[15:12];
        rs = instr[7:4];
        rt = instr[3:0];
        // sw reads rs as base, its data in rd never stalls
        rs_rd = valid && ((op <= op_addi) || (op == op_lw) || (op == op_sw) || (op == op_br));
        rt_rd = valid && (op <= op_xor);
        ld_hz = m_dx_ld && (m_dx_rd != zero_reg) &&
                ((rs_rd && (rs == m_dx_rd)) || (rt_rd && (rt == m_dx_rd)));
        br_hz = valid && (op == op_br) && taken &&
                ((m_dx_wr && (m_dx_rd != zero_reg) && (m_dx_rd == rs)) ||
                 (m_xm_wr && (m_xm_rd != zero_reg) && (m_xm_rd == rs)));
        stall = ld_hz || br_hz;
        flush = valid && ((op == op_b) || (op == op_br)) && taken && !stall;
        return {stall, stall, stall, flush};
    endfunction

    // one rising edge of the reference records
    task automatic advance_model(instr_t instr, logic valid, logic stall);
        if (reset) begin
            m_dx_wr = 1'b0;
            m_dx_ld = 1'b0;
            m_xm_wr = 1'b0;
        end else begin
            m_xm_rd = m_dx_rd;
            m_xm_wr = m_dx_wr;
            m_dx_rd = instr[11:8];
            // a held or empty slot goes on as a bubble
            m_dx_wr = valid && writes_rd(instr[15:12]) && !stall;
            m_dx_ld = valid && (instr[15:12] == op_lw) && !stall;
        end
    endtask

    task automatic compare_bit(string name, logic actual, logic want);
        checks++;
        assert (actual === want) else begin
            $display("CHECK FAILED time %0t %s expected %b got %b", $time, name, want, actual);
            errors++;
        end
    endtask

    // outputs are stable here, inputs move only on the falling edge
    always @(posedge clk) begin
        expected = expect_outputs(fd_instr, fd_valid, fd_branch_taken);
        compare_bit("pc_hold", pc_hold, expected[3]);
        compare_bit("fd_hold", fd_hold, expected[2]);
        compare_bit("dx_bubble", dx_bubble, expected[1]);
        compare_bit("fd_flush", fd_flush, expected[0]);
        model_stall = expected[3];
        seen_hold   = pc_hold;
        seen_flush  = fd_flush;
        advance_model(fd_instr, fd_valid, expected[3]);
    end

    // called on a falling edge, keeps the word in decode while stalled
    task automatic issue(input instr_t instr, input logic valid, input logic taken,
                         output int stalls, output logic flushed);
        int   waited;
        logic done;
        fd_instr        = instr;
        fd_valid        = valid;
        fd_branch_taken = taken;
        stalls  = 0;
        flushed = 1'b0;
        waited  = 0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            waited++;
            if (seen_hold)
                stalls++;
            if (!model_stall) begin
                flushed = seen_flush;
                done    = 1'b1;
            end else if (waited >= hold_limit) begin
                $display("timeout: instruction %h still held in decode after %0d cycles",
                         instr, waited);
                $display("Test failed");
                $finish;
            end
        end
    endtask

    // issue one word and check stall length and flush against hand values
    task automatic expect_issue(string what, instr_t instr, logic taken, int want_stalls,
                                logic want_flush);
        int   got_stalls;
        logic got_flush;
        issue(instr, 1'b1, taken, got_stalls, got_flush);
        checks++;
        assert (got_stalls == want_stalls && got_flush == want_flush) else begin
            $display("CHECK FAILED time %0t %s stall cycles expected %0d got %0d, flush %b got %b",
                     $time, what, want_stalls, got_stalls, want_flush, got_flush);
            errors++;
        end
    endtask

    // two empty slots push everything out of execute and memory
    task automatic drain();
        repeat (2) issue(make_instr(op_nop, 0, 0, 0), 1'b0, 1'b0, n_stall, n_flush);
    endtask

    task automatic end_test(string name);
        tests++;
        if (errors > err_mark) begin
            failed_tests++;
            $display("test %s: FAIL, %0d errors", name, errors - err_mark);
        end else begin
            $display("test %s: ok", name);
        end
        err_mark = errors;
    endtask

    initial begin
        opcode_t op;
        void'($urandom(32'hc551));
        clk             = 1'b0;
        reset           = 1'b1;
        fd_valid        = 1'b0;
        fd_instr        = '0;
        fd_branch_taken = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // an empty slot with a taken branch word must do nothing
        repeat (3) issue(make_instr(op_br, 0, 4'd5, 0), 1'b0, 1'b1, n_stall, n_flush);
        end_test("reset");

        expect_issue("lw r3", make_instr(op_lw, 3, 1, 2), 1'b0, 0, 1'b0);
        expect_issue("add rs=r3", make_instr(op_add, 4, 3, 5), 1'b0, 1, 1'b0);
        drain();
        expect_issue("lw r3", make_instr(op_lw, 3, 1, 2), 1'b0, 0, 1'b0);
        expect_issue("add rt=r3", make_instr(op_add, 4, 5, 3), 1'b0, 1, 1'b0);
        drain();
        expect_issue("lw r3", make_instr(op_lw, 3, 1, 2), 1'b0, 0, 1'b0);
        expect_issue("ror imm=3", make_instr(op_ror, 4, 5, 3), 1'b0, 0, 1'b0);
        expect_issue("lw r3", make_instr(op_lw, 3, 1, 2), 1'b0, 0, 1'b0);
        expect_issue("addi imm=3", make_instr(op_addi, 4, 5, 3), 1'b0, 0, 1'b0);
        expect_issue("lw r0", make_instr(op_lw, 0, 1, 2), 1'b0, 0, 1'b0);
        expect_issue("add r0,r0", make_instr(op_add, 4, 0, 0), 1'b0, 0, 1'b0);
        drain();
        end_test("load_use");

        expect_issue("lw r3", make_instr(op_lw, 3, 1, 2), 1'b0, 0, 1'b0);
        expect_issue("sw data=r3", make_instr(op_sw, 3, 5, 1), 1'b0, 0, 1'b0);
        expect_issue("lw r3", make_instr(op_lw, 3, 1, 2), 1'b0, 0, 1'b0);
        expect_issue("sw base=r3", make_instr(op_sw, 6, 3, 1), 1'b0, 1, 1'b0);
        drain();
        end_test("store_after_load");

        expect_issue("add r7", make_instr(op_add, 7, 1, 2), 1'b0, 0, 1'b0);
        expect_issue("br r7 next", make_instr(op_br, 0, 7, 0), 1'b1, 2, 1'b1);
        drain();
        expect_issue("add r7", make_instr(op_add, 7, 1, 2), 1'b0, 0, 1'b0);
        expect_issue("add r8", make_instr(op_add, 8, 1, 2), 1'b0, 0, 1'b0);
        expect_issue("br r7 gap", make_instr(op_br, 0, 7, 0), 1'b1, 1, 1'b1);
        drain();
        expect_issue("add r7", make_instr(op_add, 7, 1, 2), 1'b0, 0, 1'b0);
        expect_issue("br r7 untaken", make_instr(op_br, 0, 7, 0), 1'b0, 0, 1'b0);
        expect_issue("sw r7", make_instr(op_sw, 7, 7, 1), 1'b0, 0, 1'b0);
        expect_issue("br untaken after sw", make_instr(op_br, 0, 7, 0), 1'b0, 0, 1'b0);
        expect_issue("sw r7", make_instr(op_sw, 7, 7, 1), 1'b0, 0, 1'b0);
        expect_issue("br taken after sw", make_instr(op_br, 0, 7, 0), 1'b1, 0, 1'b1);
        drain();
        end_test("register_branch");

        expect_issue("add r2", make_instr(op_add, 2, 1, 1), 1'b0, 0, 1'b0);
        expect_issue("b taken", make_instr(op_b, 2, 2, 2), 1'b1, 0, 1'b1);
        drain();
        end_test("flush");

        // every opcode including the unused holes, checked cycle by cycle
        repeat (400) begin
            op = opcode_t'($urandom % 16);
            issue(make_instr(op, reg_addr_t'($urandom), reg_addr_t'($urandom),
                             reg_addr_t'($urandom)),
                  ($urandom % 4) != 0, 1'($urandom % 2), n_stall, n_flush);
        end
        end_test("random_stream");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
common/hazard_pkg.sv
common/hazard_if.sv
source/instr_decode.sv
hazard/load_use_detect.sv
hazard/branch_reg_detect.sv
hazard/hazard_control.sv
source/hazard_top.sv
testbench/hazard_tb.sv
